/* boot_rst_ctrl.f */
+incdir+design
design/boot_rst_pkg.sv
design/boot_seq_fsm.sv
design/fuse_capture.sv
design/rst_out_stage.sv
design/boot_rst_ctrl.sv
dv/boot_rst_ctrl_properties.sv
dv/tb_boot_rst_ctrl.sv

/* Bender.yml */
package:
  name: boot_rst_ctrl

export_include_dirs:
  - design

sources:
  - design/boot_rst_pkg.sv
  - design/boot_seq_fsm.sv
  - design/fuse_capture.sv
  - design/rst_out_stage.sv
  - design/boot_rst_ctrl.sv
  - target: test
    files:
      - dv/boot_rst_ctrl_properties.sv
      - dv/tb_boot_rst_ctrl.sv

/* dv/tb_boot_rst_ctrl.sv */
// drives boot_rst_ctrl on the falling clock edge and checks it on the rising edge within 600 cycles

`default_nettype none

`include "boot_rst_defs.svh"

module tb_boot_rst_ctrl
    import boot_rst_pkg::*;
();

    // five tests of about sixty cycles plus the longest firmware wait and some slack
    localparam int TEST_COUNT      = 5;
    localparam int CYCLES_PER_TEST = 60;
    localparam int MAX_WAIT        = 20;
    localparam int MARGIN_CYCLES   = 280;
    localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST + MAX_WAIT + MARGIN_CYCLES;

    logic                    clk;
    logic                    cptra_pwrgood;
    logic                    cptra_rst_b;
    logic                    scan_mode;
    logic                    fw_update_rst;
    logic [`BOOT_WAIT_W-1:0] fw_update_rst_wait_cycles;
    logic                    bootfsm_brkpoint;
    logic                    bootfsm_continue;
    fuse_wr_t                fuse_wr;
    logic                    fuse_done_wr;
    logic                    ready_for_fuses;
    boot_fsm_state_e         boot_fsm_ps;
    fuse_bank_t              fuse_bank;
    logic                    cptra_noncore_rst_b;
    logic                    cptra_uc_rst_b;
    logic                    iccm_unlock;
    logic                    fw_upd_rst_executed;
    logic                    rdc_clk_dis;
    logic                    fw_update_rst_window;

    // model state kept by the stimulus and read by the comparing process
    fuse_bank_t exp_bank;
    logic       exp_locked;
    logic       fw_check_en;
    int         uc_low_cycles;
    int         unlock_pulses;
    int         exp_wait;
    int         errors;
    int         err_before;
    int         tests_failed;
    int         cycles;
    int         total_errors;

    boot_rst_ctrl u_dut (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .scan_mode                 (scan_mode),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .bootfsm_brkpoint          (bootfsm_brkpoint),
        .bootfsm_continue          (bootfsm_continue),
        .fuse_wr                   (fuse_wr),
        .fuse_done_wr              (fuse_done_wr),
        .ready_for_fuses           (ready_for_fuses),
        .boot_fsm_ps               (boot_fsm_ps),
        .fuse_bank                 (fuse_bank),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .rdc_clk_dis               (rdc_clk_dis),
        .fw_update_rst_window      (fw_update_rst_window)
    );

    bind boot_rst_ctrl boot_rst_ctrl_properties u_props (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .scan_mode            (scan_mode),
        .boot_fsm_ps          (boot_fsm_ps),
        .cptra_noncore_rst_b  (cptra_noncore_rst_b),
        .cptra_uc_rst_b       (cptra_uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .rdc_clk_dis          (rdc_clk_dis),
        .fw_update_rst_window (fw_update_rst_window)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // a word lands only during the fuse phase and only while the bank is still open
    function automatic fuse_bank_t predict_bank(input fuse_bank_t bank, input fuse_wr_t wr,
                                                input logic fuse_phase, input logic locked);
        fuse_bank_t next_bank;
        next_bank = bank;
        if (wr.wr && fuse_phase && !locked) begin
            next_bank[wr.idx] = wr.data;
        end
        return next_bank;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        errors++;
    endtask

    // the model bank follows one cycle after the strobe, like the register
    task automatic write_fuse(input logic [`BOOT_FUSE_IDX_W-1:0] idx,
                              input logic [`BOOT_FUSE_W-1:0] data, input logic fuse_phase);
        fuse_wr_t   wr;
        fuse_bank_t next_bank;
        wr.wr   = 1'b1;
        wr.idx  = idx;
        wr.data = data;
        @(negedge clk);
        fuse_wr   = wr;
        next_bank = predict_bank(exp_bank, wr, fuse_phase, exp_locked);
        @(negedge clk);
        fuse_wr  = '0;
        exp_bank = next_bank;
    endtask

    task automatic write_done();
        @(negedge clk);
        fuse_done_wr = 1'b1;
        @(negedge clk);
        fuse_done_wr = 1'b0;
        exp_locked   = 1'b1;
    endtask

    task automatic warm_reset();
        @(negedge clk);
        cptra_rst_b = 1'b0;
        repeat (4) @(negedge clk);
        cptra_rst_b = 1'b1;
    endtask

    task automatic wait_ready();
        while (ready_for_fuses !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_resets_high();
        while (!(cptra_noncore_rst_b === 1'b1 && cptra_uc_rst_b === 1'b1)) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
        err_before = errors;
    endtask

    // comparing process, it samples at the rising edge before the flops update
    always @(posedge clk) begin
        if (cptra_pwrgood) begin
            if (fuse_bank !== exp_bank) begin
                $display("ERR t=%0t fuse_bank exp=%h got=%h", $time, exp_bank, fuse_bank);
                errors++;
            end
            // during a firmware reset the non-core domain must stay up
            if (fw_check_en) begin
                if (cptra_uc_rst_b === 1'b0) begin
                    uc_low_cycles++;
                end
                if (iccm_unlock === 1'b1) begin
                    unlock_pulses++;
                end
                if (iccm_unlock === 1'b1 && cptra_uc_rst_b === 1'b1) begin
                    report_failure("iccm_unlock came after the core left reset");
                end
                check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b1);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        cptra_pwrgood             = 1'b0;
        cptra_rst_b               = 1'b0;
        scan_mode                 = 1'b0;
        fw_update_rst             = 1'b0;
        fw_update_rst_wait_cycles = '0;
        bootfsm_brkpoint          = 1'b0;
        bootfsm_continue          = 1'b0;
        fuse_wr                   = '0;
        fuse_done_wr              = 1'b0;
        exp_bank                  = '0;
        exp_locked                = 1'b0;
        fw_check_en               = 1'b0;
        uc_low_cycles             = 0;
        unlock_pulses             = 0;
        exp_wait                  = 0;
        errors                    = 0;
        err_before                = 0;
        tests_failed              = 0;
        cycles                    = 0;
        void'($urandom(32'h05b368d7));

        // cold boot, the reset values are checked before power good rises
        repeat (4) @(negedge clk);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        check_bit("iccm_unlock", iccm_unlock, 1'b0);
        check_bit("rdc_clk_dis", rdc_clk_dis, 1'b1);
        if (boot_fsm_ps !== BOOT_IDLE) begin
            report_failure("state is not idle during cold reset");
        end
        cptra_pwrgood = 1'b1;
        cptra_rst_b   = 1'b1;
        wait_ready();
        for (int i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            write_fuse(i[`BOOT_FUSE_IDX_W-1:0], $urandom(), 1'b1);
        end
        write_done();
        wait_resets_high();
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        end_test("cold boot");

        // locked writes are dropped both before and after the warm reset
        write_fuse(0, $urandom(), 1'b0);
        warm_reset();
        check_bit("rdc_clk_dis", rdc_clk_dis, 1'b1);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        wait_ready();
        write_fuse(1, $urandom(), 1'b1);
        repeat (8) @(negedge clk);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        write_done();
        wait_resets_high();
        end_test("lock and warm reset");

        // the breakpoint parks the core in reset until continue
        @(negedge clk);
        bootfsm_brkpoint = 1'b1;
        warm_reset();
        wait_ready();
        write_done();
        while (cptra_noncore_rst_b !== 1'b1) @(negedge clk);
        repeat (6) @(negedge clk);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        bootfsm_continue = 1'b1;
        while (cptra_uc_rst_b !== 1'b1) @(negedge clk);
        bootfsm_brkpoint = 1'b0;
        bootfsm_continue = 1'b0;
        end_test("breakpoint");

        // firmware update reset with a random hold time
        @(negedge clk);
        exp_wait                  = 4 + ($urandom() % 17);
        fw_update_rst_wait_cycles = exp_wait[`BOOT_WAIT_W-1:0];
        uc_low_cycles             = 0;
        unlock_pulses             = 0;
        fw_check_en               = 1'b1;
        @(negedge clk);
        fw_update_rst = 1'b1;
        @(negedge clk);
        fw_update_rst = 1'b0;
        while (cptra_uc_rst_b !== 1'b0) @(negedge clk);
        // the core reset is being cycled so the window must be open
        check_bit("fw_update_rst_window", fw_update_rst_window, 1'b1);
        while (cptra_uc_rst_b !== 1'b1) @(negedge clk);
        fw_check_en = 1'b0;
        // the sequencer is back in done once the core has left reset
        check_bit("fw_update_rst_window", fw_update_rst_window, 1'b0);
        if (uc_low_cycles < exp_wait) begin
            report_failure($sformatf("core reset held %0d cycles, shorter than the wait of %0d",
                                     uc_low_cycles, exp_wait));
        end
        if (unlock_pulses != 1) begin
            report_failure($sformatf("iccm_unlock pulsed %0d times instead of once",
                                     unlock_pulses));
        end
        repeat (4) @(negedge clk);
        check_bit("fw_upd_rst_executed", fw_upd_rst_executed, 1'b1);
        end_test("firmware update reset");

        // scan holds both resets released through a warm reset
        @(negedge clk);
        scan_mode   = 1'b1;
        @(negedge clk);
        cptra_rst_b = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b1);
            check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b1);
        end
        cptra_rst_b = 1'b1;
        // leave scan while the reset window still gates the clocks
        @(negedge clk);
        scan_mode = 1'b0;
        @(negedge clk);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        check_bit("fw_upd_rst_executed", fw_upd_rst_executed, 1'b0);
        wait_ready();
        write_done();
        wait_resets_high();
        end_test("scan mode");

        total_errors = errors + u_dut.u_props.assert_failures;
        $display("tests %0d, failing tests %0d, check errors %0d, assertion failures %0d",
                 TEST_COUNT, tests_failed, errors, u_dut.u_props.assert_failures);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/boot_rst_ctrl_properties.sv */
// reset output checks bound into boot_rst_ctrl, every property is disabled while cptra_pwrgood is low

`default_nettype none

module boot_rst_ctrl_properties
    import boot_rst_pkg::*;
(
    input logic            clk,
    input logic            cptra_pwrgood,
    input logic            scan_mode,
    input boot_fsm_state_e boot_fsm_ps,
    input logic            cptra_noncore_rst_b,
    input logic            cptra_uc_rst_b,
    input logic            iccm_unlock,
    input logic            rdc_clk_dis,
    input logic            fw_update_rst_window
);

    // the testbench reads this count when it builds its final verdict
    int unsigned assert_failures = 0;

    // the state register must hold a known value once power is good
    state_known: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        !$isunknown(boot_fsm_ps))
        else begin
            $error("boot state is unknown");
            assert_failures++;
        end

    // the non-core reset may only drop while clocks are gated for RDC
    noncore_fall_gated: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(cptra_noncore_rst_b) |-> rdc_clk_dis)
        else begin
            $error("cptra_noncore_rst_b fell outside the reset window");
            assert_failures++;
        end

    // a core reset comes either from a firmware update or from a warm reset
    uc_fall_gated: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(cptra_uc_rst_b) |-> (fw_update_rst_window || rdc_clk_dis))
        else begin
            $error("cptra_uc_rst_b fell outside any reset window");
            assert_failures++;
        end

    // the instruction memory opens for a single cycle
    unlock_one_cycle: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        iccm_unlock |=> !iccm_unlock)
        else begin
            $error("iccm_unlock stayed high for more than one cycle");
            assert_failures++;
        end

    // scan keeps both resets released
    scan_forces_release: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        scan_mode |-> (cptra_noncore_rst_b && cptra_uc_rst_b))
        else begin
            $error("a reset output is low while scan_mode is high");
            assert_failures++;
        end

endmodule

`default_nettype wire

/* design/boot_rst_ctrl.sv */
// boot and reset sequencing top, fuse data is only captured in the fuse state and survives warm reset

`default_nettype none

`include "boot_rst_defs.svh"

module boot_rst_ctrl
    import boot_rst_pkg::*;
(
    input  logic                    clk,
    input  logic                    cptra_pwrgood,
    input  logic                    cptra_rst_b,
    input  logic                    scan_mode,
    input  logic                    fw_update_rst,
    input  logic [`BOOT_WAIT_W-1:0] fw_update_rst_wait_cycles,
    input  logic                    bootfsm_brkpoint,
    input  logic                    bootfsm_continue,
    input  fuse_wr_t                fuse_wr,
    input  logic                    fuse_done_wr,
    output logic                    ready_for_fuses,
    output boot_fsm_state_e         boot_fsm_ps,
    output fuse_bank_t              fuse_bank,
    output logic                    cptra_noncore_rst_b,
    output logic                    cptra_uc_rst_b,
    output logic                    iccm_unlock,
    output logic                    fw_upd_rst_executed,
    output logic                    rdc_clk_dis,
    output logic                    fw_update_rst_window
);

    boot_rst_req_t rst_req;
    fuse_status_t  fuse_status;
    logic          uc_rst_synced_b;

    // sequencer decides when each reset may be released
    boot_seq_fsm u_seq_fsm (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .bootfsm_brkpoint          (bootfsm_brkpoint),
        .bootfsm_continue          (bootfsm_continue),
        .fuse_status               (fuse_status),
        .uc_rst_synced_b           (uc_rst_synced_b),
        .boot_fsm_ps               (boot_fsm_ps),
        .ready_for_fuses           (ready_for_fuses),
        .rst_req                   (rst_req),
        .rdc_clk_dis               (rdc_clk_dis),
        .fw_update_rst_window      (fw_update_rst_window)
    );

    // fuse words and lock, its status gates the exit from the fuse state
    fuse_capture u_fuse_capture (
        .clk             (clk),
        .cptra_pwrgood   (cptra_pwrgood),
        .cptra_rst_b     (cptra_rst_b),
        .fuse_wr         (fuse_wr),
        .fuse_done_wr    (fuse_done_wr),
        .ready_for_fuses (ready_for_fuses),
        .fuse_bank       (fuse_bank),
        .fuse_status     (fuse_status)
    );

    // turns the sequencer requests into the reset outputs
    rst_out_stage u_rst_out (
        .clk                 (clk),
        .cptra_pwrgood       (cptra_pwrgood),
        .cptra_rst_b         (cptra_rst_b),
        .scan_mode           (scan_mode),
        .rst_req             (rst_req),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .cptra_uc_rst_b      (cptra_uc_rst_b),
        .uc_rst_synced_b     (uc_rst_synced_b),
        .iccm_unlock         (iccm_unlock),
        .fw_upd_rst_executed (fw_upd_rst_executed)
    );

endmodule

`default_nettype wire

/* design/rst_out_stage.sv */
// reset output flops, outputs follow a request after exactly two clocks and scan_mode forces both resets inactive

`default_nettype none

module rst_out_stage
    import boot_rst_pkg::*;
(
    input  logic          clk,
    input  logic          cptra_pwrgood,
    input  logic          cptra_rst_b,
    input  logic          scan_mode,
    input  boot_rst_req_t rst_req,
    output logic          cptra_noncore_rst_b,
    output logic          cptra_uc_rst_b,
    output logic          uc_rst_synced_b,
    output logic          iccm_unlock,
    output logic          fw_upd_rst_executed
);

    // first synchronizing stage of each request
    logic noncore_sync_b;
    logic uc_sync_b;

    // second stage, these drive the reset outputs
    logic noncore_rst_q_b;
    logic uc_rst_q_b;

    logic iccm_unlock_q;
    logic fw_rst_seen_q;

    // the reset flops sit on power good only
    // a warm reset reaches them through the sequencer going back to idle
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            noncore_sync_b  <= 1'b0;
            uc_sync_b       <= 1'b0;
            noncore_rst_q_b <= 1'b0;
            uc_rst_q_b      <= 1'b0;
        end else begin
            noncore_sync_b  <= rst_req.noncore_rst_req_b;
            uc_sync_b       <= rst_req.uc_rst_req_b;
            noncore_rst_q_b <= noncore_sync_b;
            // the core leaves reset only when the global and the firmware reset both allow it
            uc_rst_q_b      <= noncore_sync_b & uc_sync_b;
        end
    end

    // the sequencer watches the first stage to know the core reset is on its way
    assign uc_rst_synced_b = uc_sync_b;

    // scan must never see these resets toggle
    assign cptra_noncore_rst_b = noncore_rst_q_b | scan_mode;
    assign cptra_uc_rst_b      = uc_rst_q_b | scan_mode;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            iccm_unlock_q <= 1'b0;
            fw_rst_seen_q <= 1'b0;
        end else begin
            iccm_unlock_q <= rst_req.iccm_unlock_req;
            // once set this stays until the next warm or cold reset
            // so a 1 here means the last core reset came from a firmware update
            if (rst_req.fw_rst_start) begin
                fw_rst_seen_q <= 1'b1;
            end
        end
    end

    assign iccm_unlock         = iccm_unlock_q;
    assign fw_upd_rst_executed = fw_rst_seen_q;

endmodule

`default_nettype wire

/* design/fuse_capture.sv */
// fuse word bank, words and the lock clear only on cptra_pwrgood and writes are ignored outside the fuse state

`default_nettype none

module fuse_capture
    import boot_rst_pkg::*;
(
    input  logic         clk,
    input  logic         cptra_pwrgood,
    input  logic         cptra_rst_b,
    input  fuse_wr_t     fuse_wr,
    input  logic         fuse_done_wr,
    input  logic         ready_for_fuses,
    output fuse_bank_t   fuse_bank,
    output fuse_status_t fuse_status
);

    fuse_bank_t fuse_bank_q;
    logic       fuse_done_q;
    logic       done_observed_q;
    logic       fuse_wr_accept;
    logic       done_accept;

    // a word can only be written while the sequencer asks for fuses and before the lock
    assign fuse_wr_accept = fuse_wr.wr & ready_for_fuses & ~fuse_done_q;

    // done is taken whenever the sequencer is in the fuse state
    // a second write after warm reset just refreshes the observed flag
    assign done_accept = fuse_done_wr & ready_for_fuses;

    // the words keep their values across warm reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            fuse_bank_q <= '0;
        end else if (fuse_wr_accept) begin
            fuse_bank_q[fuse_wr.idx] <= fuse_wr.data;
        end
    end

    // sticky lock, only a power cycle opens the bank again
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            fuse_done_q <= 1'b0;
        end else if (done_accept) begin
            fuse_done_q <= 1'b1;
        end
    end

    // cleared by warm reset so the sequencer waits for a fresh done write
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            done_observed_q <= 1'b0;
        end else if (done_accept) begin
            done_observed_q <= 1'b1;
        end
    end

    assign fuse_bank                         = fuse_bank_q;
    assign fuse_status.fuse_done             = fuse_done_q;
    assign fuse_status.fuse_wr_done_observed = done_observed_q;

endmodule

`default_nettype wire

/* design/boot_seq_fsm.sv */
// boot state machine, expects cptra_rst_b low whenever cptra_pwrgood is low and a warm reset pulse of several cycles

`default_nettype none

`include "boot_rst_defs.svh"

module boot_seq_fsm
    import boot_rst_pkg::*;
(
    input  logic                    clk,
    input  logic                    cptra_pwrgood,
    input  logic                    cptra_rst_b,
    input  logic                    fw_update_rst,
    input  logic [`BOOT_WAIT_W-1:0] fw_update_rst_wait_cycles,
    input  logic                    bootfsm_brkpoint,
    input  logic                    bootfsm_continue,
    input  fuse_status_t            fuse_status,
    input  logic                    uc_rst_synced_b,
    output boot_fsm_state_e         boot_fsm_ps,
    output logic                    ready_for_fuses,
    output boot_rst_req_t           rst_req,
    output logic                    rdc_clk_dis,
    output logic                    fw_update_rst_window
);

    boot_fsm_state_e         boot_fsm_ns;

    // warm reset window, first stage is set directly by cptra_rst_b
    logic                    rst_window;
    logic                    rst_window_f;
    logic                    rst_window_2f;
    logic                    rst_window_3f;

    logic [`BOOT_WAIT_W-1:0] wait_cnt;
    logic                    wait_load;
    logic                    wait_decr;
    logic                    brk_hold;
    logic                    wait_exit;

    // a breakpoint holds the core only until continue is seen
    assign brk_hold = bootfsm_brkpoint & ~bootfsm_continue;

    // leave the wait state when the count has run out and nothing holds the core
    assign wait_exit = (wait_cnt == '0) & ~brk_hold;

    // clocks stay gated for the three cycles that follow the synchronized window
    assign rdc_clk_dis = rst_window_f | rst_window_2f | rst_window_3f;

    // marks the cycles where only the core reset is being cycled
    // other domains use it to mask paths out of the core reset flops
    assign fw_update_rst_window = (boot_fsm_ps == BOOT_FW_RST) || (boot_fsm_ps == BOOT_WAIT);

    always_comb begin
        boot_fsm_ns     = boot_fsm_ps;
        rst_req         = '0;
        ready_for_fuses = 1'b0;
        wait_load       = 1'b0;
        wait_decr       = 1'b0;

        unique case (boot_fsm_ps)
            BOOT_IDLE: begin
                // both resets stay asserted here
                if (!rst_window) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                ready_for_fuses = 1'b1;
                // the lock alone is not enough after a warm reset
                // the SoC has to write done again
                if (fuse_status.fuse_done && fuse_status.fuse_wr_done_observed) begin
                    if (bootfsm_brkpoint) begin
                        boot_fsm_ns = BOOT_WAIT;
                    end else begin
                        boot_fsm_ns = BOOT_DONE;
                    end
                end
            end
            BOOT_FW_RST: begin
                rst_req.noncore_rst_req_b = 1'b1;
                // reload every cycle so the latest programmed count is taken
                wait_load                 = 1'b1;
                // move on once the core reset has reached the synchronizer
                if (!uc_rst_synced_b) begin
                    boot_fsm_ns = BOOT_WAIT;
                end
            end
            BOOT_WAIT: begin
                rst_req.noncore_rst_req_b = 1'b1;
                wait_decr                 = 1'b1;
                if (wait_exit) begin
                    boot_fsm_ns             = BOOT_DONE;
                    // instruction memory opens only at the very end of the reset flow
                    rst_req.iccm_unlock_req = 1'b1;
                end
            end
            BOOT_DONE: begin
                rst_req.noncore_rst_req_b = 1'b1;
                rst_req.uc_rst_req_b      = 1'b1;
                if (fw_update_rst) begin
                    boot_fsm_ns          = BOOT_FW_RST;
                    rst_req.fw_rst_start = 1'b1;
                end
            end
            default: begin
                boot_fsm_ns = BOOT_IDLE;
            end
        endcase
    end

    // state and the tail of the window chain live on power good
    // the tail resets high so clocks stay gated coming out of cold reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_fsm_ps   <= BOOT_IDLE;
            rst_window_f  <= 1'b1;
            rst_window_2f <= 1'b1;
            rst_window_3f <= 1'b1;
        end else begin
            // a warm reset pulls the sequencer back to idle from any state
            if (rst_window_f) begin
                boot_fsm_ps <= BOOT_IDLE;
            end else begin
                boot_fsm_ps <= boot_fsm_ns;
            end
            rst_window_f  <= rst_window;
            rst_window_2f <= rst_window_f;
            rst_window_3f <= rst_window_2f;
        end
    end

    // window opens asynchronously and closes on the first clock after release
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window <= 1'b1;
        end else begin
            rst_window <= 1'b0;
        end
    end

    // down counter for the firmware reset hold time
    // it parks at zero, so the breakpoint path through wait sees zero at once
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wait_cnt <= '0;
        end else if (wait_load) begin
            wait_cnt <= fw_update_rst_wait_cycles;
        end else if (wait_decr && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/boot_rst_pkg.sv */
// types shared by the boot sequencer blocks, sizes come from boot_rst_defs.svh which must be on the include path

`default_nettype none

`include "boot_rst_defs.svh"

package boot_rst_pkg;

    // boot sequencer states
    // the idle encoding is zero so a cleared register lands in idle
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // per-cycle request from the sequencer to the reset output stage
    // the two reset requests are active low, the other fields are pulses
    typedef struct packed {
        logic noncore_rst_req_b;
        logic uc_rst_req_b;
        logic iccm_unlock_req;
        logic fw_rst_start;
    } boot_rst_req_t;

    // one fuse word write from the SoC, wr is a single cycle strobe
    typedef struct packed {
        logic                        wr;
        logic [`BOOT_FUSE_IDX_W-1:0] idx;
        logic [`BOOT_FUSE_W-1:0]     data;
    } fuse_wr_t;

    // the whole fuse bank, word 0 sits in the low bits
    typedef logic [`BOOT_FUSE_WORDS-1:0][`BOOT_FUSE_W-1:0] fuse_bank_t;

    // fuse_done is the lock that survives warm reset
    // fuse_wr_done_observed says done was written since the last warm reset
    typedef struct packed {
        logic fuse_done;
        logic fuse_wr_done_observed;
    } fuse_status_t;

endpackage

`default_nettype wire

/* design/boot_rst_defs.svh */
// sizes of the boot sequencer, the fuse index width must cover the word count and wait cycles are limited to 2**BOOT_WAIT_W-1

`ifndef BOOT_RST_DEFS_SVH
`define BOOT_RST_DEFS_SVH

// number of fuse words the SoC writes before fuse done
`define BOOT_FUSE_WORDS 4

// width of one fuse word
`define BOOT_FUSE_W 32

// width of the word index carried by a fuse write
// keep this at clog2 of the word count
`define BOOT_FUSE_IDX_W 2

// width of the firmware reset wait counter
// this is also the width of the programmed wait cycle count
`define BOOT_WAIT_W 8

`endif
